//--- Makefile
# Verilator build for the memory subsystem testbench

VERILATOR = verilator
FLAGS     = --timing
TB_TOP    = tb_memSubsystem
RTL_TOP   = memSubsystemTop
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

# Lint the synthesizable design on its own top level
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Build and run the testbench, then look for the pass line in the log
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
src/memBusPkg.sv
src/wbSlaveMux.sv
src/sramByteInterface.sv
src/busStatusRegs.sv
src/memSubsystemTop.sv
testbench/sramModel.sv
testbench/tb_memSubsystem.sv

//--- src/busStatusRegs.sv
// ========================================
// Wishbone register slave for bus status
// SRAM read and write counters, a scratch
// register and a fixed device ID
// ========================================
module busStatusRegs (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                cs_i,
	input  logic                cyc_i,
	input  logic                stb_i,
	input  logic                we_i,
	input  memBusPkg::busWord_t adr_i,
	input  memBusPkg::busWord_t dat_i,
	input  logic                accessDone_i,
	input  logic                accessWrite_i,
	output logic                ack_o,
	output memBusPkg::busWord_t dat_o
);

	memBusPkg::regAddr_t regSel;
	memBusPkg::busWord_t readCount;
	memBusPkg::busWord_t writeCount;
	memBusPkg::busWord_t scratch;
	logic accept;
	logic writeAccept;

	// Address bits 3:2 pick one of the four registers
	assign regSel = memBusPkg::regAddr_t'(adr_i[3:2]);

	// A strobe is taken once, while ack is still low
	assign accept = cs_i & cyc_i & stb_i & ~ack_o;
	assign writeAccept = accept & we_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			readCount <= '0;
			writeCount <= '0;
			scratch <= '0;
		end else begin
			// Ack follows the strobe by one cycle and falls after the strobe drops
			if (accept) begin
				ack_o <= 1'b1;
			end else if (!(cs_i & cyc_i & stb_i)) begin
				ack_o <= 1'b0;
			end
			// A bus write to a counter clears it, otherwise it counts finished accesses
			if (writeAccept && regSel == memBusPkg::regReadCount) begin
				readCount <= '0;
			end else if (accessDone_i && !accessWrite_i) begin
				readCount <= readCount + 32'd1;
			end
			if (writeAccept && regSel == memBusPkg::regWriteCount) begin
				writeCount <= '0;
			end else if (accessDone_i && accessWrite_i) begin
				writeCount <= writeCount + 32'd1;
			end
			// Writes to the ID register fall through and change nothing
			if (writeAccept && regSel == memBusPkg::regScratch) begin
				scratch <= dat_i;
			end
		end
	end

	// Read data is captured together with the acknowledge
	always_ff @(posedge clk_i) begin
		if (accept && !we_i) begin
			case (regSel)
				memBusPkg::regReadCount:  dat_o <= readCount;
				memBusPkg::regWriteCount: dat_o <= writeCount;
				memBusPkg::regScratch:    dat_o <= scratch;
				default:                  dat_o <= memBusPkg::DEVICE_ID;
			endcase
		end
	end

endmodule

//--- src/memBusPkg.sv
// ========================================
// Shared bus types for the memory subsystem
// Word and byte-lane types, SRAM interface states,
// register offsets and address region constants
// ========================================
package memBusPkg;

	// One 32-bit bus data word
	typedef logic [31:0] busWord_t;

	// One select bit per byte lane of a word
	typedef logic [3:0] byteSel_t;

	// States of the byte-serializing SRAM interface
	typedef enum logic [3:0] {
		idle,
		readSettle,
		readLatch,
		writeSetup,
		writePulse,
		writeHold,
		done,
		waitRelease
	} sramState_t;

	// Register offsets in the register region, taken from address bits 3:2
	typedef enum logic [1:0] {
		regReadCount  = 2'd0,
		regWriteCount = 2'd1,
		regScratch    = 2'd2,
		regId         = 2'd3
	} regAddr_t;

	// Address bit 31 set selects the register region, clear selects SRAM
	localparam int REG_REGION_BIT = 31;

	// Fixed value returned by the ID register
	localparam busWord_t DEVICE_ID = 32'h5352_4D31;

endpackage

//--- src/memSubsystemTop.sv
// ========================================
// Memory subsystem top level
// Bus mux, SRAM byte interface and status registers
// ========================================
module memSubsystemTop #(
	parameter int SRAM_ADDR_WIDTH = 19,
	parameter int SETTLE_CYCLES = 1
) (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic                       cyc_i,
	input  logic                       stb_i,
	input  logic                       we_i,
	input  memBusPkg::byteSel_t        sel_i,
	input  memBusPkg::busWord_t        adr_i,
	input  memBusPkg::busWord_t        dat_i,
	output logic                       ack_o,
	output memBusPkg::busWord_t        dat_o,
	output logic                       ramCEn_o,
	output logic                       ramWEn_o,
	output logic                       ramOEn_o,
	output logic [SRAM_ADDR_WIDTH-1:0] memAdr_o,
	output logic [7:0]                 memDbOut_o,
	output logic                       memDbOe_o,
	input  logic [7:0]                 memDb_i
);

	logic sramCs;
	logic regCs;
	logic sramAck;
	logic regAck;
	logic accessDone;
	logic accessWrite;
	memBusPkg::busWord_t sramDat;
	memBusPkg::busWord_t regDat;

	// Address decode and response selection
	wbSlaveMux i_mux (
		.clk_i(clk_i), .rst_i(rst_i), .cyc_i(cyc_i), .stb_i(stb_i), .adr_i(adr_i),
		.sramAck_i(sramAck), .sramDat_i(sramDat), .regAck_i(regAck), .regDat_i(regDat),
		.sramCs_o(sramCs), .regCs_o(regCs), .ack_o(ack_o), .dat_o(dat_o)
	);

	// External SRAM, one byte per access
	sramByteInterface #(
		.SRAM_ADDR_WIDTH(SRAM_ADDR_WIDTH),
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) i_sram (
		.clk_i(clk_i), .rst_i(rst_i), .cs_i(sramCs), .cyc_i(cyc_i), .stb_i(stb_i),
		.we_i(we_i), .sel_i(sel_i), .adr_i(adr_i), .dat_i(dat_i), .memDb_i(memDb_i),
		.ack_o(sramAck), .dat_o(sramDat), .accessDone_o(accessDone),
		.accessWrite_o(accessWrite), .ramCEn_o(ramCEn_o), .ramWEn_o(ramWEn_o),
		.ramOEn_o(ramOEn_o), .memAdr_o(memAdr_o), .memDbOut_o(memDbOut_o),
		.memDbOe_o(memDbOe_o)
	);

	// Status registers, counting the SRAM accesses
	busStatusRegs i_regs (
		.clk_i(clk_i), .rst_i(rst_i), .cs_i(regCs), .cyc_i(cyc_i), .stb_i(stb_i),
		.we_i(we_i), .adr_i(adr_i), .dat_i(dat_i), .accessDone_i(accessDone),
		.accessWrite_i(accessWrite), .ack_o(regAck), .dat_o(regDat)
	);

endmodule

//--- src/sramByteInterface.sv
// ========================================
// Wishbone slave for an 8-bit asynchronous SRAM
// Serializes one 32-bit cycle into byte accesses,
// from the lowest selected lane to the highest
// ========================================
module sramByteInterface #(
	parameter int SRAM_ADDR_WIDTH = 19,
	parameter int SETTLE_CYCLES = 1
) (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic                       cs_i,
	input  logic                       cyc_i,
	input  logic                       stb_i,
	input  logic                       we_i,
	input  memBusPkg::byteSel_t        sel_i,
	input  memBusPkg::busWord_t        adr_i,
	input  memBusPkg::busWord_t        dat_i,
	input  logic [7:0]                 memDb_i,
	output logic                       ack_o,
	output memBusPkg::busWord_t        dat_o,
	output logic                       accessDone_o,
	output logic                       accessWrite_o,
	output logic                       ramCEn_o,
	output logic                       ramWEn_o,
	output logic                       ramOEn_o,
	output logic [SRAM_ADDR_WIDTH-1:0] memAdr_o,
	output logic [7:0]                 memDbOut_o,
	output logic                       memDbOe_o
);

	// Last value of the settle counter before a read byte is latched
	localparam logic [2:0] SETTLE_LAST = 3'(SETTLE_CYCLES - 1);

	memBusPkg::sramState_t state;
	memBusPkg::busWord_t writeData;
	memBusPkg::byteSel_t laneRing;
	memBusPkg::byteSel_t firstRing;
	logic [2:0] settleCount;
	logic [1:0] firstLane;
	logic [1:0] lane;
	logic request;
	logic lastLane;
	logic writeOp;

	assign request = cs_i & cyc_i & stb_i;

	// The two low address bits name the byte lane being accessed
	assign lane = memAdr_o[1:0];

	// Bit 0 of the ring is the current lane, so no higher lane left means the end
	assign lastLane = (laneRing[3:1] == 3'b000);

	// Write data for the current lane goes straight out to the data pins
	assign memDbOut_o = writeData[{lane, 3'b000} +: 8];

	// The status block sees one pulse per finished access, in the done state
	assign accessDone_o = (state == memBusPkg::done);
	assign accessWrite_o = writeOp;

	// ========================================
	// First lane of the sequence
	// ========================================

	// The lowest selected lane starts the sequence
	always_comb begin
		casez (sel_i)
			4'b???1: firstLane = 2'd0;
			4'b??10: firstLane = 2'd1;
			4'b?100: firstLane = 2'd2;
			4'b1000: firstLane = 2'd3;
			default: firstLane = 2'd0;
		endcase
	end

	// Shift the selects down so the ring starts at the first lane
	assign firstRing = sel_i >> firstLane;

	// ========================================
	// Control state machine
	// ========================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= memBusPkg::idle;
			ack_o <= 1'b0;
			ramCEn_o <= 1'b1;
			ramWEn_o <= 1'b1;
			ramOEn_o <= 1'b1;
			memDbOe_o <= 1'b0;
			laneRing <= '0;
			settleCount <= '0;
			writeOp <= 1'b0;
		end else begin
			case (state)
				memBusPkg::idle: begin
					if (request) begin
						// Select the RAM and remember the direction of this access
						ramCEn_o <= 1'b0;
						laneRing <= firstRing;
						settleCount <= '0;
						writeOp <= we_i;
						if (we_i) begin
							memDbOe_o <= 1'b1;
							state <= memBusPkg::writeSetup;
						end else begin
							ramOEn_o <= 1'b0;
							state <= memBusPkg::readSettle;
						end
					end
				end
				// Give the address and the RAM output time to settle
				memBusPkg::readSettle: begin
					if (settleCount == SETTLE_LAST) begin
						state <= memBusPkg::readLatch;
					end else begin
						settleCount <= settleCount + 3'd1;
					end
				end
				// The byte is latched at the end of this cycle, then the lane advances
				memBusPkg::readLatch: begin
					laneRing <= {1'b0, laneRing[3:1]};
					settleCount <= '0;
					if (lastLane) begin
						ramCEn_o <= 1'b1;
						ramOEn_o <= 1'b1;
						state <= memBusPkg::done;
					end else begin
						state <= memBusPkg::readSettle;
					end
				end
				// An unselected lane keeps write-enable high so its byte is untouched
				memBusPkg::writeSetup: begin
					ramWEn_o <= ~laneRing[0];
					state <= memBusPkg::writePulse;
				end
				// Rising write-enable makes the RAM store the byte
				memBusPkg::writePulse: begin
					ramWEn_o <= 1'b1;
					state <= memBusPkg::writeHold;
				end
				// Data stays on the pins for one more cycle before the lane moves
				memBusPkg::writeHold: begin
					laneRing <= {1'b0, laneRing[3:1]};
					if (lastLane) begin
						ramCEn_o <= 1'b1;
						memDbOe_o <= 1'b0;
						state <= memBusPkg::done;
					end else begin
						state <= memBusPkg::writeSetup;
					end
				end
				memBusPkg::done: begin
					ack_o <= 1'b1;
					state <= memBusPkg::waitRelease;
				end
				// Hold ack until the master drops its strobe
				memBusPkg::waitRelease: begin
					if (!request) begin
						ack_o <= 1'b0;
						state <= memBusPkg::idle;
					end
				end
				default: state <= memBusPkg::idle;
			endcase
		end
	end

	// ========================================
	// Address and data path
	// ========================================
	always_ff @(posedge clk_i) begin
		case (state)
			memBusPkg::idle: begin
				if (request) begin
					memAdr_o <= {adr_i[SRAM_ADDR_WIDTH-1:2], firstLane};
					writeData <= dat_i;
				end
			end
			// Every visited lane is latched, selected or not
			memBusPkg::readLatch: begin
				dat_o[{lane, 3'b000} +: 8] <= memDb_i;
				memAdr_o[1:0] <= lane + 2'd1;
			end
			memBusPkg::writeHold: memAdr_o[1:0] <= lane + 2'd1;
			default: ;
		endcase
	end

endmodule

//--- src/wbSlaveMux.sv
// ========================================
// Wishbone address decoder and response mux
// Routes the strobe to the SRAM or register slave
// and returns the owner's data and acknowledge
// ========================================
module wbSlaveMux (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                cyc_i,
	input  logic                stb_i,
	input  memBusPkg::busWord_t adr_i,
	input  logic                sramAck_i,
	input  memBusPkg::busWord_t sramDat_i,
	input  logic                regAck_i,
	input  memBusPkg::busWord_t regDat_i,
	output logic                sramCs_o,
	output logic                regCs_o,
	output logic                ack_o,
	output memBusPkg::busWord_t dat_o
);

	logic busy;
	logic ownerReg;
	logic ackSeen;
	logic selAck;

	// The region bit alone decides which slave is selected
	assign regCs_o = adr_i[memBusPkg::REG_REGION_BIT];
	assign sramCs_o = ~adr_i[memBusPkg::REG_REGION_BIT];

	// Ack and data come from the slave latched as owner of the cycle
	assign selAck = ownerReg ? regAck_i : sramAck_i;

	assign ack_o = busy & selAck;
	assign dat_o = busy ? (ownerReg ? regDat_i : sramDat_i) : '0;

	// ========================================
	// Owner of the cycle in progress
	// ========================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy <= 1'b0;
			ownerReg <= 1'b0;
			ackSeen <= 1'b0;
		end else if (!busy) begin
			if (cyc_i && stb_i) begin
				busy <= 1'b1;
				ownerReg <= regCs_o;
				ackSeen <= 1'b0;
			end
		end else if (selAck) begin
			ackSeen <= 1'b1;
		end else if (ackSeen) begin
			// Ack has fallen, so a new strobe here starts the next cycle
			if (cyc_i && stb_i) begin
				ownerReg <= regCs_o;
				ackSeen <= 1'b0;
			end else begin
				busy <= 1'b0;
			end
		end
	end

endmodule

//--- testbench/sramModel.sv
// ========================================
// Behavioral 512 K by 8 asynchronous SRAM
// Stores a byte on the rising edge of write-enable
// and drives read data while selected and enabled
// ========================================
module sramModel #(
	parameter int ADDR_WIDTH = 19
) (
	input  logic                  ramCEn_i,
	input  logic                  ramWEn_i,
	input  logic                  ramOEn_i,
	input  logic [ADDR_WIDTH-1:0] memAdr_i,
	input  logic [7:0]            memDb_i,
	input  logic                  memDbOe_i,
	output logic [7:0]            memDb_o
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] mem [0:(1 << ADDR_WIDTH) - 1];

	// Power-up contents follow a pattern built from every address bit
	initial begin
		logic [31:0] fillAdr;
		for (int i = 0; i < (1 << ADDR_WIDTH); i++) begin
			fillAdr = i;
			mem[fillAdr[ADDR_WIDTH-1:0]] = fillAdr[7:0] ^ fillAdr[15:8] ^ fillAdr[23:16] ^ 8'h5A;
		end
	end

	// The byte is stored when write-enable rises while the chip is selected
	always @(posedge ramWEn_i) begin
		if (ramCEn_i === 1'b0) begin
			mem[memAdr_i] = memDb_i;
		end
	end

	// Read data appears only while nothing else drives the bus
	// A released bus reads back as zero
	assign memDb_o = (!ramCEn_i && !ramOEn_i && !memDbOe_i) ? mem[memAdr_i] : 8'h00;

endmodule

//--- testbench/tb_memSubsystem.sv
// ========================================
// Testbench for the memory subsystem
// Clock and reset, Wishbone cycle tasks, directed
// tests, compare tasks and the closing report
// ========================================
module tb_memSubsystem;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SRAM_ADDR_WIDTH = 19;
	localparam int SETTLE_CYCLES = 1;
	localparam int TIMEOUT_CYCLES = 200;

	// Register addresses sit at offsets 0, 4, 8 and 12 with bit 31 set
	localparam memBusPkg::busWord_t READ_COUNT_ADR = 32'h8000_0000;
	localparam memBusPkg::busWord_t WRITE_COUNT_ADR = 32'h8000_0004;
	localparam memBusPkg::busWord_t SCRATCH_ADR = 32'h8000_0008;
	localparam memBusPkg::busWord_t ID_ADR = 32'h8000_000C;

	// Value the ID register always reads as
	localparam memBusPkg::busWord_t EXPECTED_ID = 32'h5352_4D31;

	logic clk = 1'b0;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	memBusPkg::byteSel_t sel;
	memBusPkg::busWord_t adr;
	memBusPkg::busWord_t datW;
	logic ack;
	memBusPkg::busWord_t datR;
	logic ramCEn;
	logic ramWEn;
	logic ramOEn;
	logic [SRAM_ADDR_WIDTH-1:0] memAdr;
	logic [7:0] memDbOut;
	logic memDbOe;
	logic [7:0] memDbIn;

	int seed = 32'h01f4_d068;
	int mismatchCount = 0;
	int timeoutCount = 0;
	// SRAM cycles issued since each counter was last cleared
	int expReads = 0;
	int expWrites = 0;

	// 20 ns clock period
	always #10 clk = ~clk;

	memSubsystemTop #(
		.SRAM_ADDR_WIDTH(SRAM_ADDR_WIDTH),
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) i_dut (
		.clk_i(clk), .rst_i(rst), .cyc_i(cyc), .stb_i(stb), .we_i(we), .sel_i(sel),
		.adr_i(adr), .dat_i(datW), .ack_o(ack), .dat_o(datR), .ramCEn_o(ramCEn),
		.ramWEn_o(ramWEn), .ramOEn_o(ramOEn), .memAdr_o(memAdr), .memDbOut_o(memDbOut),
		.memDbOe_o(memDbOe), .memDb_i(memDbIn)
	);

	// External SRAM sitting on the split data bus
	sramModel #(.ADDR_WIDTH(SRAM_ADDR_WIDTH)) i_ram (
		.ramCEn_i(ramCEn), .ramWEn_i(ramWEn), .ramOEn_i(ramOEn), .memAdr_i(memAdr),
		.memDb_i(memDbOut), .memDbOe_i(memDbOe), .memDb_o(memDbIn)
	);

	// ========================================
	// Compare tasks
	// ========================================
	task automatic checkWord(input string name, input memBusPkg::busWord_t actual,
			input memBusPkg::busWord_t expected);
		if (actual !== expected) begin
			$display("FAILED %s: actual 0x%h, expected 0x%h", name, actual, expected);
			mismatchCount++;
		end
	endtask

	task automatic checkPin(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("FAILED %s: actual 0x%h, expected 0x%h", name, actual, expected);
			mismatchCount++;
		end
	endtask

	// Word with the selected lanes of the new word laid over the old one
	function automatic memBusPkg::busWord_t mergeLanes(input memBusPkg::busWord_t oldWord,
			input memBusPkg::busWord_t newWord, input memBusPkg::byteSel_t byteMask);
		memBusPkg::busWord_t result;
		result = oldWord;
		if (byteMask[0]) result[7:0] = newWord[7:0];
		if (byteMask[1]) result[15:8] = newWord[15:8];
		if (byteMask[2]) result[23:16] = newWord[23:16];
		if (byteMask[3]) result[31:24] = newWord[31:24];
		return result;
	endfunction

	// ========================================
	// Bus cycle tasks
	// ========================================

	// One classic cycle where the strobe stays up holdCycles edges after ack is seen
	task automatic busCycle(input logic write, input memBusPkg::byteSel_t byteMask,
			input memBusPkg::busWord_t address, input memBusPkg::busWord_t wrData,
			input int holdCycles, output memBusPkg::busWord_t rdData);
		int waited;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		sel <= byteMask;
		adr <= address;
		datW <= wrData;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!ack && waited < TIMEOUT_CYCLES);
		if (!ack) begin
			$display("Timeout: no acknowledge for the cycle at address 0x%h", address);
			timeoutCount++;
		end
		rdData = datR;
		// While the strobe is held the slave has to keep ack up
		for (int i = 0; i < holdCycles; i++) begin
			@(posedge clk);
			checkPin("ack_o", ack, 1'b1);
		end
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		waited = 0;
		while (ack && waited < TIMEOUT_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		if (ack) begin
			$display("Timeout: acknowledge stayed high after the strobe dropped");
			timeoutCount++;
		end
		if (!address[memBusPkg::REG_REGION_BIT]) begin
			if (write) begin
				expWrites++;
			end else begin
				expReads++;
			end
		end
	endtask

	task automatic busWrite(input memBusPkg::byteSel_t byteMask,
			input memBusPkg::busWord_t address, input memBusPkg::busWord_t data);
		memBusPkg::busWord_t unused;
		busCycle(1'b1, byteMask, address, data, 0, unused);
	endtask

	task automatic busRead(input memBusPkg::busWord_t address,
			output memBusPkg::busWord_t data);
		busCycle(1'b0, 4'hF, address, 32'h0000_0000, 0, data);
	endtask

	// ========================================
	// Directed tests
	// ========================================
	task automatic resetValues();
		checkPin("ack_o", ack, 1'b0);
		checkPin("ramCEn_o", ramCEn, 1'b1);
		checkPin("ramWEn_o", ramWEn, 1'b1);
		checkPin("ramOEn_o", ramOEn, 1'b1);
		checkPin("memDbOe_o", memDbOe, 1'b0);
	endtask

	task automatic fullWordRoundTrip();
		memBusPkg::busWord_t addrList[$];
		memBusPkg::busWord_t dataList[$];
		memBusPkg::busWord_t randWord;
		memBusPkg::busWord_t readWord;
		for (int i = 0; i < 16; i++) begin
			randWord = $random(seed);
			// The loop index in the low word-address bits keeps all 16 apart
			addrList.push_back({13'd0, randWord[16:4], i[3:0], 2'b00});
			randWord = $random(seed);
			dataList.push_back(randWord);
			busWrite(4'hF, addrList[i], dataList[i]);
		end
		for (int i = 0; i < 16; i++) begin
			busRead(addrList[i], readWord);
			checkWord("dat_o (full word)", readWord, dataList[i]);
		end
	endtask

	// Only selected lanes change and skipped middle lanes keep their byte
	task automatic partialByteWrites();
		memBusPkg::busWord_t expected;
		memBusPkg::busWord_t readWord;
		expected = 32'hA1B2_C3D4;
		busWrite(4'hF, 32'h0000_1230, expected);
		busWrite(4'b0101, 32'h0000_1230, 32'h1122_3344);
		expected = mergeLanes(expected, 32'h1122_3344, 4'b0101);
		busRead(32'h0000_1230, readWord);
		checkWord("dat_o (sel 0101)", readWord, expected);
		busWrite(4'b1000, 32'h0000_1230, 32'h5566_7788);
		expected = mergeLanes(expected, 32'h5566_7788, 4'b1000);
		busRead(32'h0000_1230, readWord);
		checkWord("dat_o (sel 1000)", readWord, expected);
		busWrite(4'b0110, 32'h0000_1230, 32'h99AA_BBCC);
		expected = mergeLanes(expected, 32'h99AA_BBCC, 4'b0110);
		busRead(32'h0000_1230, readWord);
		checkWord("dat_o (sel 0110)", readWord, expected);
	endtask

	task automatic accessCounters();
		memBusPkg::busWord_t readWord;
		busRead(READ_COUNT_ADR, readWord);
		checkWord("dat_o (read count)", readWord, expReads);
		busRead(WRITE_COUNT_ADR, readWord);
		checkWord("dat_o (write count)", readWord, expWrites);
		// Any write to a counter clears it
		busWrite(4'hF, READ_COUNT_ADR, 32'hFFFF_FFFF);
		expReads = 0;
		busRead(READ_COUNT_ADR, readWord);
		checkWord("dat_o (read count cleared)", readWord, 32'h0000_0000);
		busWrite(4'hF, WRITE_COUNT_ADR, 32'hFFFF_FFFF);
		expWrites = 0;
		busRead(WRITE_COUNT_ADR, readWord);
		checkWord("dat_o (write count cleared)", readWord, 32'h0000_0000);
		// Counting resumes from zero
		busWrite(4'hF, 32'h0000_0400, 32'h0BAD_CAFE);
		busRead(32'h0000_0400, readWord);
		busRead(READ_COUNT_ADR, readWord);
		checkWord("dat_o (read count)", readWord, expReads);
		busRead(WRITE_COUNT_ADR, readWord);
		checkWord("dat_o (write count)", readWord, expWrites);
	endtask

	task automatic scratchAndId();
		memBusPkg::busWord_t readWord;
		memBusPkg::busWord_t randWord;
		// Nothing has written the scratch register since reset
		busRead(SCRATCH_ADR, readWord);
		checkWord("dat_o (scratch after reset)", readWord, 32'h0000_0000);
		busWrite(4'hF, SCRATCH_ADR, 32'hC0DE_F00D);
		busRead(SCRATCH_ADR, readWord);
		checkWord("dat_o (scratch)", readWord, 32'hC0DE_F00D);
		randWord = $random(seed);
		busWrite(4'hF, SCRATCH_ADR, randWord);
		busRead(SCRATCH_ADR, readWord);
		checkWord("dat_o (scratch)", readWord, randWord);
		busRead(ID_ADR, readWord);
		checkWord("dat_o (ID)", readWord, EXPECTED_ID);
		busWrite(4'hF, ID_ADR, 32'h0000_0000);
		busRead(ID_ADR, readWord);
		checkWord("dat_o (ID after write)", readWord, EXPECTED_ID);
	endtask

	task automatic heldStrobe();
		memBusPkg::busWord_t readWord;
		busCycle(1'b1, 4'hF, 32'h0000_2468, 32'h1357_9BDF, 5, readWord);
		busRead(32'h0000_2468, readWord);
		checkWord("dat_o (after held write)", readWord, 32'h1357_9BDF);
		// Same rule on the register side
		busCycle(1'b0, 4'hF, ID_ADR, 32'h0000_0000, 3, readWord);
		checkWord("dat_o (held ID read)", readWord, EXPECTED_ID);
		busRead(32'h0000_2468, readWord);
		checkWord("dat_o (after held read)", readWord, 32'h1357_9BDF);
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		sel = 4'h0;
		adr = 32'h0000_0000;
		datW = 32'h0000_0000;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		resetValues();
		fullWordRoundTrip();
		partialByteWrites();
		accessCounters();
		scratchAndId();
		heldStrobe();
		$display("Errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
		if (mismatchCount == 0 && timeoutCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
